/* rtl/core_pkg.sv */
package core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [3:0]      alu_op_t;

  // major opcodes of the kept instruction groups
  localparam opcode_t op_lui   = 7'b0110111;
  localparam opcode_t op_imm   = 7'b0010011;
  localparam opcode_t op_reg   = 7'b0110011;
  localparam opcode_t op_load  = 7'b0000011;
  localparam opcode_t op_store = 7'b0100011;

  // alu function field
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // load and store widths
  localparam funct3_t f3_lb  = 3'b000;
  localparam funct3_t f3_lh  = 3'b001;
  localparam funct3_t f3_lw  = 3'b010;
  localparam funct3_t f3_lbu = 3'b100;
  localparam funct3_t f3_lhu = 3'b101;
  localparam funct3_t f3_sb  = 3'b000;
  localparam funct3_t f3_sh  = 3'b001;
  localparam funct3_t f3_sw  = 3'b010;

  // alu operations
  localparam alu_op_t alu_add    = 4'd0;
  localparam alu_op_t alu_sub    = 4'd1;
  localparam alu_op_t alu_sll    = 4'd2;
  localparam alu_op_t alu_slt    = 4'd3;
  localparam alu_op_t alu_sltu   = 4'd4;
  localparam alu_op_t alu_xor    = 4'd5;
  localparam alu_op_t alu_srl    = 4'd6;
  localparam alu_op_t alu_sra    = 4'd7;
  localparam alu_op_t alu_or     = 4'd8;
  localparam alu_op_t alu_and    = 4'd9;
  localparam alu_op_t alu_pass_b = 4'd10;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;

  typedef struct packed {
    logic     valid;
    logic     write;
    word_t    addr;
    word_t    wdata;
    byte_en_t mbe;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } ifid_t;

  typedef struct packed {
    logic     valid;
    opcode_t  opcode;
    funct3_t  funct3;
    alu_op_t  alu_op;
    reg_idx_t rs1, rs2, rd;
    word_t    rs1_val, rs2_val, imm;
    logic     use_imm, reg_write, is_load, is_store;
  } idex_t;

  typedef struct packed {
    logic     valid;
    funct3_t  funct3;
    reg_idx_t rd;
    word_t    result;
    word_t    store_val;
    logic     reg_write, is_load, is_store;
  } exmem_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
    logic     reg_write;
  } wb_t;

endpackage

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
  parameter core_pkg::word_t reset_pc = '0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               hold,
  input  logic               stall_load,
  output core_pkg::mem_req_t req,
  input  logic               ready,
  input  core_pkg::word_t    rdata,
  output core_pkg::ifid_t    ifid
);

  import core_pkg::*;

  word_t pc;
  logic  frozen;
  logic  pending;

  assign frozen = hold || stall_load;

  // a started fetch stays on the bus until it completes, frozen or not
  always_comb begin
    req.valid = !rst && (pending || !frozen);
    req.write = 1'b0;
    req.addr  = pc;
    req.wdata = '0;
    req.mbe   = '1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc         <= reset_pc;
      pending    <= 1'b0;
      ifid.valid <= 1'b0;
    end else begin
      pending <= req.valid && !ready;
      // a word that lands while frozen is dropped and fetched again
      if (!frozen) begin
        if (req.valid && ready) begin
          pc         <= pc + 32'd4;
          ifid.valid <= 1'b1;
          ifid.pc    <= pc;
          ifid.instr <= rdata;
        end else begin
          // bubble while the fetch waits
          ifid.valid <= 1'b0;
          ifid.instr <= nop_instr;
        end
      end
    end
  end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
  input  logic            clk,
  input  logic            rst,
  input  logic            hold,
  input  core_pkg::ifid_t ifid,
  input  core_pkg::wb_t   wb,
  output logic            stall_load,
  output core_pkg::idex_t idex
);

  import core_pkg::*;

  word_t    regs [32];
  opcode_t  opcode;
  funct3_t  funct3;
  reg_idx_t rs1, rs2, rd;
  word_t    imm;
  alu_op_t  alu_op;
  idex_t    idex_next;

  assign opcode = ifid.instr[6:0];
  assign rd     = ifid.instr[11:7];
  assign funct3 = ifid.instr[14:12];
  assign rs1    = ifid.instr[19:15];
  assign rs2    = ifid.instr[24:20];

  // *******************************************************************
  // register file
  // *******************************************************************

  // x0 reads zero, writeback is visible in the same cycle
  function automatic word_t read_reg(reg_idx_t idx);
    word_t val;
    val = regs[idx];
    if (idx == '0) begin
      val = '0;
    end else if (wb.valid && wb.reg_write && wb.rd == idx) begin
      val = wb.data;
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (wb.valid && wb.reg_write) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // *******************************************************************
  // control
  // *******************************************************************

  always_comb begin
    case (opcode)
      op_lui:   imm = {ifid.instr[31:12], 12'h000};
      op_store: imm = {{20{ifid.instr[31]}}, ifid.instr[31:25], ifid.instr[11:7]};
      default:  imm = {{20{ifid.instr[31]}}, ifid.instr[31:20]};
    endcase
  end

  // loads and stores add for the address
  always_comb begin
    alu_op = alu_add;
    if (opcode == op_lui) begin
      alu_op = alu_pass_b;
    end else if (opcode == op_imm || opcode == op_reg) begin
      case (funct3)
        f3_add:  alu_op = (opcode == op_reg && ifid.instr[30]) ? alu_sub : alu_add;
        f3_sll:  alu_op = alu_sll;
        f3_slt:  alu_op = alu_slt;
        f3_sltu: alu_op = alu_sltu;
        f3_xor:  alu_op = alu_xor;
        f3_sr:   alu_op = ifid.instr[30] ? alu_sra : alu_srl;
        f3_or:   alu_op = alu_or;
        f3_and:  alu_op = alu_and;
        default: alu_op = alu_add;
      endcase
    end
  end

  always_comb begin
    idex_next.valid     = ifid.valid;
    idex_next.opcode    = opcode;
    idex_next.funct3    = funct3;
    idex_next.alu_op    = alu_op;
    idex_next.rs1       = rs1;
    idex_next.rs2       = rs2;
    idex_next.rd        = rd;
    idex_next.rs1_val   = read_reg(rs1);
    idex_next.rs2_val   = read_reg(rs2);
    idex_next.imm       = imm;
    idex_next.use_imm   = (opcode != op_reg);
    idex_next.reg_write = (rd != '0) && (opcode == op_lui || opcode == op_imm ||
                                         opcode == op_reg || opcode == op_load);
    idex_next.is_load   = (opcode == op_load);
    idex_next.is_store  = (opcode == op_store);
  end

  // load in ID/EX feeding the instruction behind it
  assign stall_load = idex.valid && (idex.opcode == op_load) && (idex.rd != '0) &&
                      ifid.valid && (idex.rd == rs1 || idex.rd == rs2);

  always_ff @(posedge clk) begin
    if (rst) begin
      idex.valid <= 1'b0;
    end else if (!hold) begin
      if (stall_load) begin
        idex.valid <= 1'b0;
      end else begin
        idex <= idex_next;
      end
    end
  end

  // writeback from the memory stage never targets x0
  assert property (@(posedge clk) disable iff (rst)
    (wb.valid && wb.reg_write) |-> (wb.rd != '0));

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             hold,
  input  core_pkg::idex_t  idex,
  input  core_pkg::wb_t    wb,
  output core_pkg::exmem_t exmem
);

  import core_pkg::*;

  word_t a;
  word_t b;
  word_t rs2_fwd;
  word_t result;

  // *******************************************************************
  // forwarding
  // *******************************************************************

  // EX/MEM is newer than writeback, so it wins
  function automatic word_t forward(reg_idx_t idx, word_t reg_val);
    word_t val;
    val = reg_val;
    if (idx != '0) begin
      if (exmem.valid && exmem.reg_write && exmem.rd == idx) begin
        val = exmem.result;
      end else if (wb.valid && wb.reg_write && wb.rd == idx) begin
        val = wb.data;
      end
    end
    return val;
  endfunction

  always_comb begin
    a       = forward(idex.rs1, idex.rs1_val);
    rs2_fwd = forward(idex.rs2, idex.rs2_val);
    b       = idex.use_imm ? idex.imm : rs2_fwd;
  end

  // *******************************************************************
  // alu
  // *******************************************************************

  always_comb begin
    case (idex.alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << b[4:0];
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> b[4:0];
      alu_sra:    result = word_t'($signed(a) >>> b[4:0]);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exmem.valid <= 1'b0;
    end else if (!hold) begin
      exmem.valid     <= idex.valid;
      exmem.funct3    <= idex.funct3;
      exmem.rd        <= idex.rd;
      exmem.result    <= result;
      exmem.store_val <= rs2_fwd;
      exmem.reg_write <= idex.reg_write;
      exmem.is_load   <= idex.is_load;
      exmem.is_store  <= idex.is_store;
    end
  end

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::exmem_t   exmem,
  output core_pkg::mem_req_t req,
  input  logic               ready,
  input  core_pkg::word_t    rdata,
  output logic               hold,
  output core_pkg::wb_t      wb
);

  import core_pkg::*;

  logic       mem_op;
  logic [1:0] offset;
  word_t      lane;
  word_t      load_val;

  assign mem_op = exmem.valid && (exmem.is_load || exmem.is_store);
  assign offset = exmem.result[1:0];
  assign hold   = mem_op && !ready;

  // *******************************************************************
  // lane handling
  // *******************************************************************

  always_comb begin
    req.valid = mem_op;
    req.write = exmem.is_store;
    req.addr  = {exmem.result[xlen-1:2], 2'b00};
    req.wdata = exmem.store_val << {offset, 3'b000};
    req.mbe   = 4'b1111;
    if (exmem.is_store) begin
      case (exmem.funct3)
        f3_sb:   req.mbe = 4'b0001 << offset;
        f3_sh:   req.mbe = 4'b0011 << offset;
        f3_sw:   req.mbe = 4'b1111;
        default: req.mbe = 4'b1111;
      endcase
    end
  end

  // addressed byte or halfword moved down to bit 0
  always_comb begin
    lane = rdata >> {offset, 3'b000};
    case (exmem.funct3)
      f3_lb:   load_val = {{24{lane[7]}}, lane[7:0]};
      f3_lbu:  load_val = {24'b0, lane[7:0]};
      f3_lh:   load_val = {{16{lane[15]}}, lane[15:0]};
      f3_lhu:  load_val = {16'b0, lane[15:0]};
      f3_lw:   load_val = rdata;
      default: load_val = rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else if (!hold) begin
      wb.valid     <= exmem.valid;
      wb.rd        <= exmem.rd;
      wb.data      <= exmem.is_load ? load_val : exmem.result;
      wb.reg_write <= exmem.reg_write;
    end
  end

  // lh, lhu and sh must not straddle two words
  assert property (@(posedge clk) disable iff (rst)
    (mem_op && exmem.funct3[1:0] == 2'b01) |-> !exmem.result[0]);

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::mem_req_t fetch_req,
  input  core_pkg::mem_req_t data_req,
  output logic               fetch_ready,
  output logic               data_ready,
  output core_pkg::mem_req_t bus_req,
  input  logic               bus_ready
);

  typedef enum logic [1:0] {
    idle,
    grant_fetch,
    grant_data
  } arb_state_t;

  arb_state_t state;
  logic       sel_data;

  // data wins from idle, a grant sticks until its transfer completes
  assign sel_data    = (state == grant_data) || (state == idle && data_req.valid);
  assign bus_req     = sel_data ? data_req : fetch_req;
  assign data_ready  = sel_data && bus_ready;
  assign fetch_ready = !sel_data && bus_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (bus_req.valid && !bus_ready) begin
            state <= sel_data ? grant_data : grant_fetch;
          end
        end
        default: begin
          if (bus_ready) begin
            state <= idle;
          end
        end
      endcase
    end
  end

  // a waiting request neither drops nor changes until the bus takes it
  assert property (@(posedge clk) disable iff (rst)
    (bus_req.valid && !bus_ready) |=> (bus_req.valid && $stable(bus_req)));

endmodule

/* rtl/core_top.sv */
`timescale 1ns/100ps

module core_top #(
  parameter core_pkg::word_t reset_pc = '0
) (
  input  logic               clk,
  input  logic               rst,
  output core_pkg::mem_req_t mem_req,
  input  logic               mem_ready,
  input  core_pkg::word_t    mem_rdata
);

  import core_pkg::*;

  ifid_t    ifid;
  idex_t    idex;
  exmem_t   exmem;
  wb_t      wb;
  mem_req_t fetch_req;
  mem_req_t data_req;
  logic     fetch_ready;
  logic     data_ready;
  logic     hold;
  logic     stall_load;

  fetch_stage #(
    .reset_pc(reset_pc)
  ) u_fetch (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .stall_load(stall_load),
    .req       (fetch_req),
    .ready     (fetch_ready),
    .rdata     (mem_rdata),
    .ifid      (ifid)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .ifid      (ifid),
    .wb        (wb),
    .stall_load(stall_load),
    .idex      (idex)
  );

  execute_stage u_execute (
    .clk  (clk),
    .rst  (rst),
    .hold (hold),
    .idex (idex),
    .wb   (wb),
    .exmem(exmem)
  );

  // read data fans out to both requesters, ready picks the owner
  memory_stage u_memory (
    .clk  (clk),
    .rst  (rst),
    .exmem(exmem),
    .req  (data_req),
    .ready(data_ready),
    .rdata(mem_rdata),
    .hold (hold),
    .wb   (wb)
  );

  mem_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .data_req   (data_req),
    .fetch_ready(fetch_ready),
    .data_ready (data_ready),
    .bus_req    (mem_req),
    .bus_ready  (mem_ready)
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int half_period = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

/* sim/mem_model.sv */
`timescale 1ns/100ps

module mem_model #(
  parameter logic [31:0] seed_init = 32'h1
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rand_en,
  input  core_pkg::mem_req_t req,
  output logic               ready,
  output core_pkg::word_t    rdata
);

  import core_pkg::*;

  localparam int depth = 1024;

  word_t       mem [depth];
  logic        written [depth];
  integer      seed;
  int unsigned delay_left;
  logic [9:0]  idx;

  // unwritten words read as nop so the program runs off into bubbles
  assign idx   = req.addr[11:2];
  assign ready = req.valid && (delay_left == 0);
  assign rdata = written[idx] ? mem[idx] : nop_instr;

  task automatic clear_all();
    for (int i = 0; i < depth; i++) begin
      written[i] = 1'b0;
    end
  endtask

  task automatic load_word(word_t addr, word_t data);
    mem[addr[11:2]]     = data;
    written[addr[11:2]] = 1'b1;
  endtask

  initial begin
    seed       = seed_init;
    delay_left = 0;
    clear_all();
  end

  // request sampled at the edge, response updated 1 ns later
  always @(posedge clk) begin : respond
    mem_req_t   req_q;
    logic       fire;
    logic       rst_q;
    logic       rand_q;
    logic [9:0] idx_w;
    req_q  = req;
    fire   = req.valid && ready;
    rst_q  = rst;
    rand_q = rand_en;
    idx_w  = req.addr[11:2];
    #1;
    if (rst_q) begin
      delay_left = 0;
    end else if (fire) begin
      if (req_q.write) begin
        if (!written[idx_w]) begin
          mem[idx_w] = nop_instr;
        end
        for (int i = 0; i < 4; i++) begin
          if (req_q.mbe[i]) begin
            mem[idx_w][8*i +: 8] = req_q.wdata[8*i +: 8];
          end
        end
        written[idx_w] = 1'b1;
      end
      // wait for the next request, 0 to 3 cycles
      delay_left = rand_q ? ($unsigned($random(seed)) % 4) : 0;
    end else if (req_q.valid && delay_left != 0) begin
      delay_left = delay_left - 1;
    end
  end

endmodule

/* sim/core_tb.sv */
`timescale 1ns/100ps

module core_tb;

  import core_pkg::*;

  localparam logic [31:0] seed_init = 32'h3e493de5;
  // 6 tests of up to 24 instructions, 4 cycles per access, plus margin
  localparam int    cycle_limit = 1500;
  localparam word_t alu_base    = 32'h0000_0200;
  localparam word_t lu_src      = 32'h0000_0300;
  localparam word_t lu_dst      = 32'h0000_0310;
  localparam word_t sb_base     = 32'h0000_0400;
  localparam word_t ld_src      = 32'h0000_0500;
  localparam word_t ld_dst      = 32'h0000_0600;

  logic     clk;
  logic     rst;
  logic     rand_en;
  mem_req_t mem_req;
  logic     mem_ready;
  word_t    mem_rdata;
  int       errors = 0;
  int       checks = 0;
  int       cycles = 0;

  word_t    prog [$];
  word_t    init_addr [$];
  word_t    init_data [$];
  word_t    exp_addr [$];
  word_t    exp_data [$];
  byte_en_t exp_mbe [$];
  word_t    log_addr [$];
  word_t    log_data [$];
  byte_en_t log_mbe [$];

  tb_clock clock_gen (
    .clk(clk)
  );

  mem_model #(
    .seed_init(seed_init)
  ) mem_mod (
    .clk    (clk),
    .rst    (rst),
    .rand_en(rand_en),
    .req    (mem_req),
    .ready  (mem_ready),
    .rdata  (mem_rdata)
  );

  core_top #(
    .reset_pc(32'h0)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

  // *********************************************************************
  // instruction encoding
  // *********************************************************************

  function automatic word_t enc_i(opcode_t op, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                  word_t imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(funct3_t f3, logic alt, reg_idx_t rd, reg_idx_t rs1,
                                  reg_idx_t rs2);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t enc_s(funct3_t f3, reg_idx_t rs2, reg_idx_t rs1, word_t imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_u(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, op_lui};
  endfunction

  // sign or zero extended byte or halfword at a byte offset
  function automatic word_t lane_value(funct3_t f3, word_t w, int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w >> (8 * off);
    h = w >> (8 * off);
    case (f3)
      f3_lb:   return {{24{b[7]}}, b};
      f3_lbu:  return {24'h0, b};
      f3_lh:   return {{16{h[15]}}, h};
      f3_lhu:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // *********************************************************************
  // compare tasks and store log
  // *********************************************************************

  task automatic check_word(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mbe(string what, byte_en_t got, byte_en_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic verify_flag(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // a write completes where valid and ready meet
  always @(negedge clk) begin
    if (!rst && mem_req.valid && mem_req.write && mem_ready) begin
      log_addr.push_back(mem_req.addr);
      log_data.push_back(mem_req.wdata);
      log_mbe.push_back(mem_req.mbe);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles with stores still missing", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic expect_store(word_t addr, word_t data, byte_en_t mbe);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mbe.push_back(mbe);
  endtask

  task automatic new_program();
    prog.delete();
    init_addr.delete();
    init_data.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_mbe.delete();
  endtask

  // memory is loaded once the pipeline has drained under reset
  task automatic run_program(logic random_ready);
    @(posedge clk);
    #1;
    rst     = 1'b1;
    rand_en = random_ready;
    repeat (2) @(posedge clk);
    #1;
    mem_mod.clear_all();
    foreach (init_addr[i]) begin
      mem_mod.load_word(init_addr[i], init_data[i]);
    end
    foreach (prog[i]) begin
      mem_mod.load_word(4 * i, prog[i]);
    end
    log_addr.delete();
    log_data.delete();
    log_mbe.delete();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    while (log_addr.size() < exp_addr.size()) begin
      @(posedge clk);
    end
  endtask

  task automatic compare_store_log(string name);
    foreach (exp_addr[i]) begin
      check_word($sformatf("%s store %0d addr", name, i), log_addr[i], exp_addr[i]);
      check_word($sformatf("%s store %0d data", name, i), log_data[i], exp_data[i]);
      check_mbe($sformatf("%s store %0d mbe", name, i), log_mbe[i], exp_mbe[i]);
    end
  endtask

  // *********************************************************************
  // directed tests
  // *********************************************************************

  task automatic reset_sequence();
    new_program();
    repeat (5) begin
      @(posedge clk);
      #1;
      verify_flag("mem_req.valid in reset", mem_req.valid, 1'b0);
    end
    rst = 1'b0;
    @(negedge clk);
    verify_flag("first request valid", mem_req.valid, 1'b1);
    verify_flag("first request write", mem_req.write, 1'b0);
    check_word("first request addr", mem_req.addr, 32'h0);
  endtask

  // each result feeds the next, stores go out after the chain
  task automatic alu_chain(logic random_ready);
    word_t res [8];
    new_program();
    res[0] = -300;
    res[1] = res[0] + res[0];
    res[2] = res[0] - res[1];
    res[3] = res[2] ^ res[1];
    res[4] = ($signed(res[3]) < $signed(res[2])) ? 32'd1 : 32'd0;
    res[5] = $signed(res[1]) >>> res[4][4:0];
    res[6] = 32'hABCD_E000;
    res[7] = res[6] + res[5];
    prog.push_back(enc_i(op_imm, f3_add, 1, 0, -300));
    prog.push_back(enc_r(f3_add, 1'b0, 2, 1, 1));
    prog.push_back(enc_r(f3_add, 1'b1, 3, 1, 2));
    prog.push_back(enc_r(f3_xor, 1'b0, 4, 3, 2));
    prog.push_back(enc_r(f3_slt, 1'b0, 5, 4, 3));
    prog.push_back(enc_r(f3_sr, 1'b1, 6, 2, 5));
    prog.push_back(enc_u(7, 20'hABCDE));
    prog.push_back(enc_r(f3_add, 1'b0, 8, 7, 6));
    prog.push_back(enc_s(f3_sw, 8, 0, alu_base));
    expect_store(alu_base, res[7], 4'hf);
    for (int k = 0; k < 7; k++) begin
      prog.push_back(enc_s(f3_sw, reg_idx_t'(k + 1), 0, alu_base + 4 * (k + 1)));
      expect_store(alu_base + 4 * (k + 1), res[k], 4'hf);
    end
    run_program(random_ready);
    compare_store_log(random_ready ? "back-pressure" : "alu chain");
  endtask

  task automatic load_use();
    word_t src;
    new_program();
    src = 32'h1234_5678;
    init_addr.push_back(lu_src);
    init_data.push_back(src);
    prog.push_back(enc_i(op_load, f3_lw, 1, 0, lu_src));
    prog.push_back(enc_i(op_imm, f3_add, 2, 1, 32'h55));
    prog.push_back(enc_s(f3_sw, 2, 0, lu_dst));
    prog.push_back(enc_i(op_load, f3_lw, 3, 0, lu_src));
    prog.push_back(enc_r(f3_add, 1'b0, 4, 3, 3));
    prog.push_back(enc_s(f3_sw, 4, 0, lu_dst + 4));
    expect_store(lu_dst, src + 32'h55, 4'hf);
    expect_store(lu_dst + 4, src + src, 4'hf);
    run_program(1'b0);
    compare_store_log("load-use");
  endtask

  task automatic store_lanes();
    word_t val;
    new_program();
    val = 32'h8765_4321;
    prog.push_back(enc_u(1, 20'h87654));
    prog.push_back(enc_i(op_imm, f3_add, 1, 1, 32'h321));
    for (int off = 0; off < 4; off++) begin
      prog.push_back(enc_s(f3_sb, 1, 0, sb_base + off));
      expect_store(sb_base, val << (8 * off), 4'b0001 << off);
    end
    for (int off = 0; off < 4; off += 2) begin
      prog.push_back(enc_s(f3_sh, 1, 0, sb_base + 4 + off));
      expect_store(sb_base + 4, val << (8 * off), 4'b0011 << off);
    end
    run_program(1'b0);
    compare_store_log("store lanes");
  endtask

  // every load is stored back right away, so each one also stalls
  task automatic load_lanes();
    funct3_t f3s [12];
    int      offs [12];
    word_t   src;
    new_program();
    f3s  = '{f3_lb, f3_lb, f3_lb, f3_lb, f3_lbu, f3_lbu, f3_lbu, f3_lbu,
             f3_lh, f3_lh, f3_lhu, f3_lhu};
    offs = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 2, 0, 2};
    src  = 32'h7B9A_F00D;
    init_addr.push_back(ld_src);
    init_data.push_back(src);
    for (int k = 0; k < 12; k++) begin
      prog.push_back(enc_i(op_load, f3s[k], 1, 0, ld_src + offs[k]));
      prog.push_back(enc_s(f3_sw, 1, 0, ld_dst + 4 * k));
      expect_store(ld_dst + 4 * k, lane_value(f3s[k], src, offs[k]), 4'hf);
    end
    run_program(1'b0);
    compare_store_log("load lanes");
  endtask

  initial begin
    rst     = 1'b1;
    rand_en = 1'b0;
    reset_sequence();
    alu_chain(1'b0);
    load_use();
    store_lanes();
    load_lanes();
    alu_chain(1'b1);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mem_arbiter.sv
rtl/core_top.sv
sim/tb_clock.sv
sim/mem_model.sv
sim/core_tb.sv
